/* all.f */
src/lpif_pkg.sv
src/ll_auto_sync.sv
src/lpif_field_pack.sv
src/lpif_lane_concat.sv
src/lpif_txrx_x4_top.sv
sim/lpif_tb.sv

/* sim/lpif_tb.sv */
`timescale 1ns/1ps

module lpif_tb
  import lpif_pkg::*;
();

  localparam int DATA_W    = 64;
  localparam int NUM_LANES = 4;
  // Lane geometry from the packed word size
  localparam int PAY_W     = (DATA_W + CTRL_W + NUM_LANES - 1) / NUM_LANES;
  localparam int LANE_W    = PAY_W + LANE_CTRL_W;
  localparam int PHY_W     = LANE_W * NUM_LANES;

  localparam int NUM_WORDS = 50;
  localparam int DELAY_Z   = 5;
  localparam int DELAY_X   = 3;
  localparam logic [NUM_LANES-1:0] LANE2_KILL = NUM_LANES'(1) << 2;

  // Run limit from the per-test lengths plus margin
  localparam int TIMEOUT_CYCLES = 10 + (DELAY_Z + DELAY_X + 10) + (NUM_WORDS + 8) + 12 + 10 + 500;

  typedef struct packed {
    link_state_e            state;
    logic [PROTID_W-1:0]    protid;
    logic [DATA_W-1:0]      data;
    logic [DVALID_W-1:0]    dvalid;
    logic [CRC_W-1:0]       crc;
    logic [CRC_VALID_W-1:0] crc_valid;
    logic [VALID_W-1:0]     valid;
  } word_t;

  logic                   clk;
  logic                   arst_n;
  logic                   tx_online;
  logic                   rx_online;
  logic [DELAY_W-1:0]     delay_x_value;
  logic [DELAY_W-1:0]     delay_z_value;
  logic [PHY_W-1:0]       tx_phy;
  logic [PHY_W-1:0]       rx_phy;
  link_state_e            ustrm_state;
  logic [PROTID_W-1:0]    ustrm_protid;
  logic [DATA_W-1:0]      ustrm_data;
  logic [DVALID_W-1:0]    ustrm_dvalid;
  logic [CRC_W-1:0]       ustrm_crc;
  logic [CRC_VALID_W-1:0] ustrm_crc_valid;
  logic [VALID_W-1:0]     ustrm_valid;
  link_state_e            dstrm_state;
  logic [PROTID_W-1:0]    dstrm_protid;
  logic [DATA_W-1:0]      dstrm_data;
  logic [DVALID_W-1:0]    dstrm_dvalid;
  logic [CRC_W-1:0]       dstrm_crc;
  logic [CRC_VALID_W-1:0] dstrm_crc_valid;
  logic [VALID_W-1:0]     dstrm_valid;
  logic [31:0]            tx_upstream_debug_status;
  logic [31:0]            rx_downstream_debug_status;

  logic [NUM_LANES-1:0]   strobe_kill;
  logic [PHY_W-1:0]       kill_bus;
  logic [PHY_W-1:0]       ctrl_mask;
  logic                   rx_link_up;
  word_t                  exp_q[$];
  int                     err_cnt;
  int                     chk_cnt;
  int                     cycle_cnt;

  lpif_txrx_x4_top #(
    .DATA_W    (DATA_W),
    .NUM_LANES (NUM_LANES)
  ) i_dut (
    .clk_wr                     (clk),
    .arst_n                     (arst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_z_value              (delay_z_value),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .tx_upstream_debug_status   (tx_upstream_debug_status),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

  ////////////////////
  // PHY loopback

  // Strobe sits just above each lane payload and the marker above that
  always_comb begin
    kill_bus  = '0;
    ctrl_mask = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      kill_bus[k*LANE_W + PAY_W]      = strobe_kill[k];
      ctrl_mask[k*LANE_W + PAY_W]     = 1'b1;
      ctrl_mask[k*LANE_W + PAY_W + 1] = 1'b1;
    end
  end

  assign rx_phy = tx_phy & ~kill_bus;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////
  // Compare tasks

  task automatic check_data(input string name, input logic [PHY_W-1:0] got,
                            input logic [PHY_W-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_state(input string name, input link_state_e got, input link_state_e exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  ////////////////////
  // Stimulus helpers

  function automatic word_t idle_word();
    word_t w;
    w       = '0;
    w.state = ACTIVE;
    return w;
  endfunction

  function automatic word_t random_word();
    word_t w;
    case ($urandom % 6)
      0: w.state = RESET;
      1: w.state = ACTIVE;
      2: w.state = RETRAIN;
      3: w.state = L1;
      4: w.state = L2;
      default: w.state = LINKERROR;
    endcase
    w.protid    = PROTID_W'($urandom);
    w.data      = {$urandom, $urandom};
    w.dvalid    = DVALID_W'($urandom);
    w.crc       = CRC_W'($urandom);
    w.crc_valid = CRC_VALID_W'($urandom);
    // Some words carry no valid bits
    w.valid     = VALID_W'($urandom);
    return w;
  endfunction

  task automatic drive_word(input word_t w);
    ustrm_state     = w.state;
    ustrm_protid    = w.protid;
    ustrm_data      = w.data;
    ustrm_dvalid    = w.dvalid;
    ustrm_crc       = w.crc;
    ustrm_crc_valid = w.crc_valid;
    ustrm_valid     = w.valid;
  endtask

  // Receive gate seen by this word is the strobe mask driven one cycle after it
  task automatic check_word(input word_t exp);
    logic gate;
    gate = rx_link_up && (strobe_kill == '0);
    check_state("dstrm_state", dstrm_state, exp.state);
    check_data("dstrm_protid", dstrm_protid, exp.protid);
    check_data("dstrm_data", dstrm_data, exp.data);
    check_data("dstrm_crc", dstrm_crc, exp.crc);
    check_data("dstrm_dvalid", dstrm_dvalid, gate ? exp.dvalid : '0);
    check_data("dstrm_crc_valid", dstrm_crc_valid, gate ? exp.crc_valid : '0);
    check_data("dstrm_valid", dstrm_valid, gate ? exp.valid : '0);
  endtask

  // Words come out two cycles after they go in
  task automatic send_word(input word_t w, input logic [NUM_LANES-1:0] kill);
    word_t exp;
    @(negedge clk);
    if (exp_q.size() == 2) begin
      exp = exp_q.pop_front();
      check_word(exp);
    end
    drive_word(w);
    strobe_kill = kill;
    exp_q.push_back(w);
  endtask

  // Flush the pipe and wait one spare cycle for the rx counters
  task automatic drain_words();
    word_t exp;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      exp = exp_q.pop_front();
      check_word(exp);
      drive_word(idle_word());
      strobe_kill = '0;
    end
    @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      drive_word(idle_word());
      strobe_kill = '0;
    end
  endtask

  ////////////////////
  // Directed tests

  task automatic reset_values();
    check_data("tx_phy", tx_phy, '0);
    check_data("dstrm_valid", dstrm_valid, '0);
    check_data("dstrm_dvalid", dstrm_dvalid, '0);
    check_data("dstrm_crc_valid", dstrm_crc_valid, '0);
    check_count("tx_upstream_debug_status", tx_upstream_debug_status, '0);
    check_count("rx_downstream_debug_status", rx_downstream_debug_status, '0);
  endtask

  // Online rises delay+1 cycles after the first sampling edge
  task automatic online_delay_seq();
    word_t busy;
    busy       = idle_word();
    busy.valid = 2'b11;
    @(negedge clk);
    drive_word(busy);
    tx_online = 1'b1;
    // tx_phy one register behind tx_online_delay
    for (int n = 1; n <= DELAY_Z + 3; n++) begin
      @(negedge clk);
      if (n <= DELAY_Z + 2) begin
        check_data("tx_phy", tx_phy, '0);
      end else begin
        check_data("tx_phy strobe/marker", tx_phy & ctrl_mask, ctrl_mask);
      end
    end
    rx_online = 1'b1;
    // Gate opens combinationally with rx_online_delay
    for (int n = 1; n <= DELAY_X + 2; n++) begin
      @(negedge clk);
      if (n <= DELAY_X + 1) begin
        check_data("dstrm_valid", dstrm_valid, '0);
      end else begin
        check_data("dstrm_valid", dstrm_valid, busy.valid);
      end
    end
    rx_link_up = 1'b1;
    idle_cycles(3);
  endtask

  task automatic loopback_burst();
    logic [31:0] tx_base;
    logic [31:0] rx_base;
    int          nvalid;
    word_t       w;
    tx_base = tx_upstream_debug_status;
    rx_base = rx_downstream_debug_status;
    nvalid  = 0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      w = random_word();
      if (w.valid != '0) begin
        nvalid++;
      end
      send_word(w, '0);
    end
    drain_words();
    check_count("tx_upstream_debug_status", tx_upstream_debug_status, tx_base + 32'(nvalid));
    // Error half stays put while the word half grows
    check_count("rx_downstream_debug_status", rx_downstream_debug_status,
                rx_base + 32'(nvalid));
  endtask

  task automatic strobe_loss();
    logic [31:0] tx_base;
    logic [31:0] rx_base;
    word_t       w;
    tx_base = tx_upstream_debug_status;
    rx_base = rx_downstream_debug_status;
    // Three valid words, each followed by a cycle of lane 2 strobe loss
    for (int i = 0; i < 3; i++) begin
      w           = random_word();
      w.valid     = 2'b11;
      w.dvalid    = 2'b11;
      w.crc_valid = 2'b11;
      send_word(w, (i == 0) ? '0 : LANE2_KILL);
    end
    send_word(idle_word(), LANE2_KILL);
    for (int i = 0; i < 3; i++) begin
      send_word(idle_word(), '0);
    end
    drain_words();
    check_count("tx_upstream_debug_status", tx_upstream_debug_status, tx_base + 32'd3);
    check_count("rx_downstream_debug_status", rx_downstream_debug_status,
                rx_base + (32'd3 << 16));
  endtask

  task automatic going_offline();
    logic [31:0] tx_base;
    logic [15:0] err_base;
    word_t       busy;
    busy       = idle_word();
    busy.valid = 2'b01;
    @(negedge clk);
    drive_word(busy);
    tx_online = 1'b0;
    // FSM drops on the first edge and tx_phy on the second
    repeat (2) @(negedge clk);
    check_data("tx_phy", tx_phy, '0);
    tx_base  = tx_upstream_debug_status;
    err_base = rx_downstream_debug_status[31:16];
    // rx capture lags one cycle, so 4 errors in 5 cycles
    repeat (5) @(negedge clk);
    check_count("tx_upstream_debug_status", tx_upstream_debug_status, tx_base);
    check_count("rx_downstream_debug_status[31:16]",
                {16'h0, rx_downstream_debug_status[31:16]},
                {16'h0, err_base} + 32'd4);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    void'($urandom(86));
    err_cnt       = 0;
    chk_cnt       = 0;
    rx_link_up    = 1'b0;
    strobe_kill   = '0;
    arst_n        = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = DELAY_W'(DELAY_X);
    delay_z_value = DELAY_W'(DELAY_Z);
    drive_word(idle_word());
    ustrm_state   = RESET;

    repeat (10) @(negedge clk);
    arst_n = 1'b1;

    reset_values();
    online_delay_seq();
    loopback_burst();
    strobe_loss();
    going_offline();

    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* src/ll_auto_sync.sv */
`timescale 1ns/1ps

module ll_auto_sync
  import lpif_pkg::*;
(
  input  logic               clk_wr,
  input  logic               arst_n,

  // Raw online indications
  input  logic               tx_online,
  input  logic               rx_online,

  // Hold-off delays in cycles
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_z_value,

  // Delayed online indications
  output logic               tx_online_delay,
  output logic               rx_online_delay
);

  // Index 0 is transmit, index 1 is receive
  logic               online_in [2];
  logic [DELAY_W-1:0] delay_in  [2];
  sync_state_e        state_q   [2];
  logic [DELAY_W-1:0] cnt_q     [2];

  // Transmit waits on delay_z, receive on delay_x
  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_in[0]  = delay_z_value;
  assign delay_in[1]  = delay_x_value;

  ////////////////////
  // Delay FSMs

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2; i++) begin
        state_q[i] <= SYNC_IDLE;
        cnt_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (state_q[i])
          SYNC_IDLE: begin
            // Load the delay on the first cycle online
            if (online_in[i]) begin
              state_q[i] <= SYNC_WAIT;
              cnt_q[i]   <= delay_in[i];
            end
          end
          SYNC_WAIT: begin
            if (!online_in[i]) begin
              state_q[i] <= SYNC_IDLE;
            end else if (cnt_q[i] == '0) begin
              state_q[i] <= SYNC_ONLINE;
            end else begin
              cnt_q[i] <= cnt_q[i] - 1'b1;
            end
          end
          SYNC_ONLINE: begin
            // Any drop of the input restarts the wait
            if (!online_in[i]) begin
              state_q[i] <= SYNC_IDLE;
            end
          end
          default: begin
            state_q[i] <= SYNC_IDLE;
          end
        endcase
      end
    end
  end

  // Outputs decoded straight from state
  assign tx_online_delay = (state_q[0] == SYNC_ONLINE);
  assign rx_online_delay = (state_q[1] == SYNC_ONLINE);

endmodule

/* src/lpif_field_pack.sv */
`timescale 1ns/1ps

module lpif_field_pack
  import lpif_pkg::*;
#(
  parameter int DATA_W    = 64,
  parameter int NUM_LANES = 4,
  // Packed word rounded up to a whole number of lane payloads
  localparam int PAY_W  = (DATA_W + CTRL_W + NUM_LANES - 1) / NUM_LANES,
  localparam int PACK_W = PAY_W * NUM_LANES
) (
  // Upstream LPIF fields
  input  link_state_e            ustrm_state,
  input  logic [PROTID_W-1:0]    ustrm_protid,
  input  logic [DATA_W-1:0]      ustrm_data,
  input  logic [DVALID_W-1:0]    ustrm_dvalid,
  input  logic [CRC_W-1:0]       ustrm_crc,
  input  logic [CRC_VALID_W-1:0] ustrm_crc_valid,
  input  logic [VALID_W-1:0]     ustrm_valid,

  // Packed transmit word
  output logic [PACK_W-1:0]      tx_word,

  // Received word and receive gate inputs
  input  logic [PACK_W-1:0]      rx_word,
  input  logic                   rx_online_delay,
  input  logic                   strobe_ok,

  // Downstream LPIF fields
  output link_state_e            dstrm_state,
  output logic [PROTID_W-1:0]    dstrm_protid,
  output logic [DATA_W-1:0]      dstrm_data,
  output logic [DVALID_W-1:0]    dstrm_dvalid,
  output logic [CRC_W-1:0]       dstrm_crc,
  output logic [CRC_VALID_W-1:0] dstrm_crc_valid,
  output logic [VALID_W-1:0]     dstrm_valid
);

  ////////////////////
  // Word layout

  // Bit 0 upward, padding above state
  localparam int OFF_VALID     = 0;
  localparam int OFF_CRC_VALID = OFF_VALID + VALID_W;
  localparam int OFF_CRC       = OFF_CRC_VALID + CRC_VALID_W;
  localparam int OFF_DVALID    = OFF_CRC + CRC_W;
  localparam int OFF_DATA      = OFF_DVALID + DVALID_W;
  localparam int OFF_PROTID    = OFF_DATA + DATA_W;
  localparam int OFF_STATE     = OFF_PROTID + PROTID_W;

  logic rx_open;

  // Pack, padding left at zero
  always_comb begin
    tx_word                                = '0;
    tx_word[OFF_VALID     +: VALID_W]      = ustrm_valid;
    tx_word[OFF_CRC_VALID +: CRC_VALID_W]  = ustrm_crc_valid;
    tx_word[OFF_CRC       +: CRC_W]        = ustrm_crc;
    tx_word[OFF_DVALID    +: DVALID_W]     = ustrm_dvalid;
    tx_word[OFF_DATA      +: DATA_W]       = ustrm_data;
    tx_word[OFF_PROTID    +: PROTID_W]     = ustrm_protid;
    tx_word[OFF_STATE     +: STATE_W]      = ustrm_state;
  end

  ////////////////////
  // Unpack

  // Receive gate, online and all strobes seen
  assign rx_open = rx_online_delay & strobe_ok;

  // Payload fields pass through ungated
  assign dstrm_state  = link_state_e'(rx_word[OFF_STATE +: STATE_W]);
  assign dstrm_protid = rx_word[OFF_PROTID +: PROTID_W];
  assign dstrm_data   = rx_word[OFF_DATA +: DATA_W];
  assign dstrm_crc    = rx_word[OFF_CRC +: CRC_W];

  // Valid-type fields forced low while the gate is shut
  assign dstrm_dvalid    = rx_open ? rx_word[OFF_DVALID +: DVALID_W] : '0;
  assign dstrm_crc_valid = rx_open ? rx_word[OFF_CRC_VALID +: CRC_VALID_W] : '0;
  assign dstrm_valid     = rx_open ? rx_word[OFF_VALID +: VALID_W] : '0;

endmodule

/* src/lpif_lane_concat.sv */
`timescale 1ns/1ps

module lpif_lane_concat
  import lpif_pkg::*;
#(
  parameter int DATA_W    = 64,
  parameter int NUM_LANES = 4,
  // Lane payload, lane with control bits, flat PHY bus
  localparam int PAY_W  = (DATA_W + CTRL_W + NUM_LANES - 1) / NUM_LANES,
  localparam int PACK_W = PAY_W * NUM_LANES,
  localparam int LANE_W = PAY_W + LANE_CTRL_W,
  localparam int PHY_W  = LANE_W * NUM_LANES
) (
  input  logic              clk_wr,
  input  logic              arst_n,

  // Delayed online indications
  input  logic              tx_online_delay,
  input  logic              rx_online_delay,

  // Packed words
  input  logic [PACK_W-1:0] tx_word,
  output logic [PACK_W-1:0] rx_word,
  output logic              strobe_ok,

  // PHY lanes, lane k at bits k*LANE_W upward
  output logic [PHY_W-1:0]  tx_phy,
  input  logic [PHY_W-1:0]  rx_phy,

  // Debug counters
  output logic [31:0]       tx_upstream_debug_status,
  output logic [31:0]       rx_downstream_debug_status
);

  logic [PHY_W-1:0]     tx_lanes;
  logic [PHY_W-1:0]     rx_phy_q;
  logic [NUM_LANES-1:0] rx_stb;

  logic                 tx_evt;
  logic                 rx_word_evt;
  logic                 rx_err_evt;
  logic [31:0]          tx_cnt;
  logic [15:0]          rx_word_cnt;
  logic [15:0]          rx_err_cnt;

  ////////////////////
  // Transmit striping

  // Payload slice low, strobe then marker above
  always_comb begin
    tx_lanes = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      tx_lanes[k*LANE_W +: PAY_W]             = tx_word[k*PAY_W +: PAY_W];
      tx_lanes[k*LANE_W + PAY_W + STB_BIT]    = 1'b1;
      // Persistent marker
      tx_lanes[k*LANE_W + PAY_W + MRK_BIT]    = 1'b1;
    end
  end

  // Lanes idle at zero until online
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else if (tx_online_delay) begin
      tx_phy <= tx_lanes;
    end else begin
      tx_phy <= '0;
    end
  end

  ////////////////////
  // Receive capture

  always_ff @(posedge clk_wr) begin
    rx_phy_q <= rx_phy;
  end

  // Strip control bits, collect strobes
  always_comb begin
    rx_word = '0;
    rx_stb  = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      rx_word[k*PAY_W +: PAY_W] = rx_phy_q[k*LANE_W +: PAY_W];
      rx_stb[k]                 = rx_phy_q[k*LANE_W + PAY_W + STB_BIT];
    end
  end

  // Every lane must show its strobe
  assign strobe_ok = &rx_stb;

  ////////////////////
  // Debug counters

  // Valid field sits at the bottom of both words
  assign tx_evt      = tx_online_delay & (|tx_word[VALID_W-1:0]);
  assign rx_word_evt = rx_online_delay & strobe_ok & (|rx_word[VALID_W-1:0]);
  assign rx_err_evt  = rx_online_delay & ~strobe_ok;

  // Saturating counts
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_cnt      <= '0;
      rx_word_cnt <= '0;
      rx_err_cnt  <= '0;
    end else begin
      if (tx_evt && (tx_cnt != '1)) begin
        tx_cnt <= tx_cnt + 1'b1;
      end
      if (rx_word_evt && (rx_word_cnt != '1)) begin
        rx_word_cnt <= rx_word_cnt + 1'b1;
      end
      // Strobe loss while online
      if (rx_err_evt && (rx_err_cnt != '1)) begin
        rx_err_cnt <= rx_err_cnt + 1'b1;
      end
    end
  end

  assign tx_upstream_debug_status   = tx_cnt;
  // Errors high, word count low
  assign rx_downstream_debug_status = {rx_err_cnt, rx_word_cnt};

endmodule

/* src/lpif_pkg.sv */
package lpif_pkg;

  ////////////////////
  // LPIF link state

  // Encodings follow the LPIF state field
  typedef enum logic [7:0] {
    RESET     = 8'h00,
    ACTIVE    = 8'h01,
    RETRAIN   = 8'h0B,
    L1        = 8'h04,
    L2        = 8'h05,
    LINKERROR = 8'h0A
  } link_state_e;

  // Per-direction online delay FSM
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_WAIT,
    SYNC_ONLINE
  } sync_state_e;

  ////////////////////
  // Field widths

  localparam int STATE_W     = $bits(link_state_e);
  localparam int PROTID_W    = 4;
  localparam int DVALID_W    = 2;
  localparam int CRC_W       = 8;
  localparam int CRC_VALID_W = 2;
  localparam int VALID_W     = 2;

  // All non-data bits of one LPIF word
  localparam int CTRL_W = STATE_W + PROTID_W + DVALID_W + CRC_W + CRC_VALID_W + VALID_W;

  // Lane control bits, above the payload
  localparam int LANE_CTRL_W = 2;
  localparam int STB_BIT     = 0;
  localparam int MRK_BIT     = 1;

  // Delay configuration inputs
  localparam int DELAY_W = 16;

endpackage

/* src/lpif_txrx_x4_top.sv */
`timescale 1ns/1ps

module lpif_txrx_x4_top
  import lpif_pkg::*;
#(
  parameter int DATA_W    = 64,
  parameter int NUM_LANES = 4,
  // PHY bus width from the lane geometry
  localparam int PAY_W  = (DATA_W + CTRL_W + NUM_LANES - 1) / NUM_LANES,
  localparam int PACK_W = PAY_W * NUM_LANES,
  localparam int PHY_W  = (PAY_W + LANE_CTRL_W) * NUM_LANES
) (
  input  logic                   clk_wr,
  input  logic                   arst_n,

  // Link control
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [DELAY_W-1:0]     delay_x_value,
  input  logic [DELAY_W-1:0]     delay_z_value,

  // PHY lanes, flat
  output logic [PHY_W-1:0]       tx_phy,
  input  logic [PHY_W-1:0]       rx_phy,

  // Upstream channel
  input  link_state_e            ustrm_state,
  input  logic [PROTID_W-1:0]    ustrm_protid,
  input  logic [DATA_W-1:0]      ustrm_data,
  input  logic [DVALID_W-1:0]    ustrm_dvalid,
  input  logic [CRC_W-1:0]       ustrm_crc,
  input  logic [CRC_VALID_W-1:0] ustrm_crc_valid,
  input  logic [VALID_W-1:0]     ustrm_valid,

  // Downstream channel
  output link_state_e            dstrm_state,
  output logic [PROTID_W-1:0]    dstrm_protid,
  output logic [DATA_W-1:0]      dstrm_data,
  output logic [DVALID_W-1:0]    dstrm_dvalid,
  output logic [CRC_W-1:0]       dstrm_crc,
  output logic [CRC_VALID_W-1:0] dstrm_crc_valid,
  output logic [VALID_W-1:0]     dstrm_valid,

  // Debug status
  output logic [31:0]            tx_upstream_debug_status,
  output logic [31:0]            rx_downstream_debug_status
);

  logic              tx_online_delay;
  logic              rx_online_delay;
  logic [PACK_W-1:0] tx_word;
  logic [PACK_W-1:0] rx_word;
  logic              strobe_ok;

  ////////////////////
  // Online hold-off

  ll_auto_sync ll_auto_sync_i (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////
  // LPIF field packing

  lpif_field_pack #(
    .DATA_W    (DATA_W),
    .NUM_LANES (NUM_LANES)
  ) lpif_field_pack_i (
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .rx_online_delay (rx_online_delay),
    .strobe_ok       (strobe_ok),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  ////////////////////
  // PHY lane striping

  lpif_lane_concat #(
    .DATA_W    (DATA_W),
    .NUM_LANES (NUM_LANES)
  ) lpif_lane_concat_i (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .tx_online_delay            (tx_online_delay),
    .rx_online_delay            (rx_online_delay),
    .tx_word                    (tx_word),
    .rx_word                    (rx_word),
    .strobe_ok                  (strobe_ok),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .tx_upstream_debug_status   (tx_upstream_debug_status),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

endmodule
